/* nes_mmc1.f */
+incdir+verilog
verilog/mmc1_pkg.sv
verilog/mmc1_serial_ctrl.sv
verilog/mmc1_prg_map.sv
verilog/mmc1_chr_map.sv
verilog/mmc1_mapper.sv
dv/mmc1_clk_gen.sv
dv/mmc1_checker.sv
dv/mmc1_tb.sv

/* dv/mmc1_tb.sv */
`timescale 1ns/1ps
`include "mmc1_defines.svh"

module mmc1_tb;

	// Serial load is 10 cycles. Reset wait, then the sum of all test sequences below.
	localparam int TEST_CYC = 3 + 4 + 8 * 46 + 23 + 8 * 18 + 16 + 46 + 1;
	localparam int LIMIT    = 2 * TEST_CYC;

	logic m2;
	logic map_rst;
	mmc1_pkg::cpu_bus_t   cpu;
	mmc1_pkg::ppu_bus_t   ppu;
	mmc1_pkg::sys_cfg_t   cfg;
	mmc1_pkg::ss_ctrl_t   ss;
	mmc1_pkg::map_out_t   act_out;
	mmc1_pkg::map_out_t   exp_out;
	mmc1_pkg::cpu_data_t  act_ss;
	mmc1_pkg::cpu_data_t  exp_ss;
	mmc1_pkg::mmc1_regs_t mdl; // Model register set.
	logic                 mdl_held;
	int                   err_cnt;
	int                   chk_cnt;
	int                   cyc = 0;

	mmc1_clk_gen u_clk (.m2(m2), .map_rst(map_rst));

	mmc1_mapper DUT (.m2(m2), .map_rst(map_rst), .cpu(cpu), .ppu(ppu), .cfg(cfg), .ss(ss),
		.map_out(act_out), .ss_rdat(act_ss));

	mmc1_checker u_chk (.m2(m2), .map_rst(map_rst), .exp_out(exp_out), .act_out(act_out),
		.exp_ss(exp_ss), .act_ss(act_ss), .err_cnt(err_cnt), .chk_cnt(chk_cnt));

	function automatic mmc1_pkg::mmc1_regs_t with_reg(input mmc1_pkg::mmc1_regs_t r,
		input logic [1:0] idx, input mmc1_pkg::mmc_reg_t v);
		case (idx)
			2'd0: r.r0 = v;
			2'd1: r.r1 = v;
			2'd2: r.r2 = v;
			default: r.r3 = v;
		endcase
		return r;
	endfunction

	function automatic mmc1_pkg::map_out_t expected_map(input mmc1_pkg::mmc1_regs_t r,
		input mmc1_pkg::cpu_bus_t c, input mmc1_pkg::ppu_bus_t p, input mmc1_pkg::sys_cfg_t f);
		mmc1_pkg::map_out_t o;
		logic [3:0] pb;
		logic [4:0] cb;
		o = '0;
		if (!r.r0[3])
			pb = {r.r3[3:1], c.addr[14]}; // 32K mode.
		else if (r.r0[2] != c.addr[14])
			pb = r.r3[3:0];
		else
			pb = {4{c.addr[14]}}; // Fixed bank 0 or 15.
		if (f.map_sub == 4'd5)
			pb[0] = c.addr[14];
		if (!r.r0[4])
			cb = {r.r1[4:1], p.addr[12]};
		else
			cb = p.addr[12] ? r.r2 : r.r1;
		o.prg_addr  = {cb[4], pb, c.addr[13:0]};
		o.prg_oe    = c.rw; // CPU read cycle.
		o.rom_ce    = c.addr[15]; // 8000 to FFFF.
		o.chr_addr  = {f.chr_ram ? {4'd0, cb[0]} : cb, p.addr[11:0]};
		o.chr_oe    = !p.oe;
		o.chr_ce    = !p.addr[13]; // Pattern tables.
		o.ciram_a10 = r.r0[1] ? (r.r0[0] ? p.addr[11] : p.addr[10]) : r.r0[0];
		o.ciram_ce  = !p.addr[13];
		o.ram_ce    = (c.addr[15:13] == 3'b011);
		o.ram_we    = o.ram_ce && !c.rw;
		o.chr_we    = f.chr_ram && !p.we && !p.addr[13];
		o.srm_addr  = {f.chr_ram ? cb[3:2] : 2'b00, c.addr[12:0]};
		return o;
	endfunction

	function automatic mmc1_pkg::cpu_data_t expected_ss(input mmc1_pkg::mmc1_regs_t r,
		input mmc1_pkg::ss_addr_t a);
		case (a)
			8'd0: return {3'b000, r.r0};
			8'd1: return {3'b000, r.r1};
			8'd2: return {3'b000, r.r2};
			8'd3: return {3'b000, r.r3};
			8'd4: return {3'b000, r.buff};
			8'd127: return 8'h01;
			default: return 8'hff;
		endcase
	endfunction

	assign exp_out = expected_map(mdl, cpu, ppu, cfg);
	assign exp_ss  = expected_ss(mdl, ss.addr);

	always @(posedge m2)
	begin
		mdl_held <= !map_rst && cpu.addr[15] && !cpu.rw && !mdl_held;
		if (ss.act && ss.we)
		begin
			if (ss.addr < 8'd4)
				mdl <= with_reg(mdl, ss.addr[1:0], cpu.dat[4:0]);
			else if (ss.addr == `MMC1_SS_BUFF_ADDR)
				mdl.buff <= cpu.dat[4:0];
		end
		else if (map_rst)
			mdl <= {`MMC1_R0_RST, 5'd0, 5'd0, 5'd0, 5'b10000};
		else if (cpu.addr[15] && !cpu.rw && !mdl_held && !ss.act)
		begin
			if (cpu.dat[7])
			begin
				mdl.buff    <= 5'b10000;
				mdl.r0[3:2] <= 2'b11;
			end
			else if (mdl.buff[0])
			begin
				mdl      <= with_reg(mdl, cpu.addr[14:13], {cpu.dat[0], mdl.buff[4:1]});
				mdl.buff <= 5'b10000; // Later assignment wins over the line above.
			end
			else
				mdl.buff <= {cpu.dat[0], mdl.buff[4:1]};
		end
	end

	always @(posedge m2)
	begin
		cyc <= cyc + 1;
		if (cyc >= LIMIT)
		begin
			$display("Timeout after %0d cycles, the test sequence did not finish", cyc);
			$display("sim failed");
			$finish;
		end
	end

	task automatic idle_cycle();
		@(negedge m2);
		cpu.addr = 16'($urandom);
		cpu.dat  = 8'($urandom);
		cpu.rw   = 1'b1;
		ppu.addr = 14'($urandom);
		ppu.oe   = 1'($urandom);
		ppu.we   = 1'($urandom);
		ss.act   = 1'b0;
		ss.addr  = 8'($urandom);
	endtask

	task automatic cpu_access(input mmc1_pkg::cpu_addr_t a, input mmc1_pkg::cpu_data_t d,
		input logic rw);
		@(negedge m2);
		cpu.addr = a;
		cpu.dat  = d;
		cpu.rw   = rw;
		ss.act   = 1'b0;
	endtask

	task automatic serial_load(input logic [1:0] idx, input mmc1_pkg::mmc_reg_t val);
		logic [12:0] lo;
		logic [5:0]  hi;
		for (int i = 0; i < 5; i++)
		begin
			lo = 13'($urandom);
			hi = 6'($urandom);
			cpu_access({1'b1, idx, lo}, {1'b0, hi, val[i]}, 1'b0);
			idle_cycle();
		end
	endtask

	task automatic reset_write();
		cpu_access(16'h8000 | 16'($urandom), 8'h80 | 8'($urandom), 1'b0);
		idle_cycle();
	endtask

	task automatic ss_access(input logic we, input mmc1_pkg::ss_addr_t a,
		input mmc1_pkg::cpu_data_t d);
		@(negedge m2);
		ss.act   = 1'b1;
		ss.we    = we;
		ss.addr  = a;
		cpu.dat  = d;
		cpu.addr = 16'h8000 | 16'($urandom); // CPU write that must be ignored.
		cpu.rw   = 1'b0;
	endtask

	initial
	begin
		void'($urandom(34));
		cpu = '0;
		cpu.rw = 1'b1;
		ppu = '0;
		ppu.oe = 1'b1;
		ppu.we = 1'b1;
		cfg = '0;
		ss = '0;
		wait (map_rst === 1'b0);
		// Power-up state, r0 readback and fixed last bank.
		ss_access(1'b0, 8'd0, 8'h00);
		cpu_access(16'hc000, 8'h00, 1'b1);
		repeat (2) idle_cycle();
		for (int m = 7; m >= 0; m--)
		begin
			serial_load(2'd0, {m[2:0], 2'($urandom)});
			serial_load(2'd1, 5'($urandom));
			serial_load(2'd2, 5'($urandom));
			serial_load(2'd3, 5'($urandom));
			repeat (6) idle_cycle();
		end
		// Partial load aborted by a reset write.
		cpu_access(16'ha000, 8'h01, 1'b0);
		idle_cycle();
		cpu_access(16'ha000, 8'h00, 1'b0);
		idle_cycle();
		reset_write();
		serial_load(2'd3, 5'($urandom));
		cpu_access(16'he000, 8'h01, 1'b0);
		cpu_access(16'he000, 8'h00, 1'b0); // Ignored second write.
		idle_cycle();
		ss_access(1'b0, `MMC1_SS_BUFF_ADDR, 8'h00);
		idle_cycle();
		reset_write();
		for (int f = 0; f < 2; f++)
		begin
			cfg.chr_ram = f[0];
			for (int m = 0; m < 4; m++)
			begin
				serial_load(2'd0, {3'($urandom), m[1:0]});
				repeat (8) idle_cycle();
			end
		end
		for (int a = 0; a < 5; a++)
			ss_access(1'b1, a[7:0], {3'($urandom), 1'b1, 4'($urandom)});
		for (int a = 0; a < 5; a++)
			ss_access(1'b0, a[7:0], 8'h00);
		ss_access(1'b0, `MMC1_SS_ID_ADDR, 8'h00);
		ss_access(1'b0, 8'd5, 8'h00);
		ss_access(1'b0, 8'h80 | 8'($urandom), 8'h00);
		idle_cycle();
		reset_write();
		// Save RAM with CHR RAM banking.
		cfg.chr_ram = 1'b1;
		serial_load(2'd1, 5'($urandom));
		repeat (8)
		begin
			cpu_access({3'b011, 13'($urandom)}, 8'($urandom), 1'b0);
			idle_cycle();
		end
		cfg.map_sub = 4'd5;
		serial_load(2'd3, 5'($urandom));
		repeat (10) idle_cycle();
		@(negedge m2);
		$display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* dv/mmc1_checker.sv */
`timescale 1ns/1ps

module mmc1_checker
(
	input  logic                m2,
	input  logic                map_rst,
	input  mmc1_pkg::map_out_t  exp_out,
	input  mmc1_pkg::map_out_t  act_out,
	input  mmc1_pkg::cpu_data_t exp_ss,
	input  mmc1_pkg::cpu_data_t act_ss,
	output int                  err_cnt,
	output int                  chk_cnt
);

	int errs = 0;
	int chks = 0;

	assign err_cnt = errs;
	assign chk_cnt = chks;

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		chks++;
		if (act !== exp)
		begin
			errs++;
			$display("Error: %s expected 0x%0h, got 0x%0h at %0t", name, exp, act, $time);
		end
	endtask

	// Outputs are combinational and settled since the falling edge.
	always @(posedge m2)
	begin
		if (!map_rst)
		begin
			compare("prg_addr", exp_out.prg_addr, act_out.prg_addr);
			compare("prg_oe", exp_out.prg_oe, act_out.prg_oe);
			compare("rom_ce", exp_out.rom_ce, act_out.rom_ce);
			compare("chr_addr", exp_out.chr_addr, act_out.chr_addr);
			compare("chr_oe", exp_out.chr_oe, act_out.chr_oe);
			compare("chr_ce", exp_out.chr_ce, act_out.chr_ce);
			compare("srm_addr", exp_out.srm_addr, act_out.srm_addr);
			compare("ciram_a10", exp_out.ciram_a10, act_out.ciram_a10);
			compare("ciram_ce", exp_out.ciram_ce, act_out.ciram_ce);
			compare("ram_ce", exp_out.ram_ce, act_out.ram_ce);
			compare("ram_we", exp_out.ram_we, act_out.ram_we);
			compare("chr_we", exp_out.chr_we, act_out.chr_we);
			compare("ss_rdat", exp_ss, act_ss);
		end
	end

endmodule

/* dv/mmc1_clk_gen.sv */
`timescale 1ns/1ps

module mmc1_clk_gen
(
	output logic m2,
	output logic map_rst
);

	initial
	begin
		m2 = 1'b0;
		forever #2 m2 = !m2; // 4 ns period.
	end

	// High over the first two rising edges.
	initial
	begin
		map_rst = 1'b1;
		repeat (2) @(negedge m2);
		map_rst = 1'b0;
	end

endmodule

/* verilog/mmc1_mapper.sv */
`timescale 1ns/1ps

module mmc1_mapper
(
	input  logic                m2,
	input  logic                map_rst,
	input  mmc1_pkg::cpu_bus_t  cpu,
	input  mmc1_pkg::ppu_bus_t  ppu,
	input  mmc1_pkg::sys_cfg_t  cfg,
	input  mmc1_pkg::ss_ctrl_t  ss,
	output mmc1_pkg::map_out_t  map_out,
	output mmc1_pkg::cpu_data_t ss_rdat
);

	mmc1_pkg::mmc1_regs_t regs;
	logic [4:0]           chr_bank; // Also feeds PRG A18 and the save RAM bank.

	mmc1_serial_ctrl u_ctrl (
		.m2      (m2),
		.map_rst (map_rst),
		.cpu     (cpu),
		.ss      (ss),
		.regs    (regs),
		.ss_rdat (ss_rdat)
	);

	mmc1_prg_map u_prg (
		.cpu      (cpu),
		.cfg      (cfg),
		.regs     (regs),
		.chr_bank (chr_bank),
		.prg_addr (map_out.prg_addr),
		.prg_oe   (map_out.prg_oe),
		.rom_ce   (map_out.rom_ce),
		.ram_ce   (map_out.ram_ce),
		.ram_we   (map_out.ram_we),
		.srm_addr (map_out.srm_addr)
	);

	mmc1_chr_map u_chr (
		.ppu       (ppu),
		.cfg       (cfg),
		.regs      (regs),
		.chr_bank  (chr_bank),
		.chr_addr  (map_out.chr_addr),
		.chr_oe    (map_out.chr_oe),
		.chr_ce    (map_out.chr_ce),
		.chr_we    (map_out.chr_we),
		.ciram_a10 (map_out.ciram_a10),
		.ciram_ce  (map_out.ciram_ce)
	);

endmodule

/* verilog/mmc1_chr_map.sv */
`timescale 1ns/1ps

module mmc1_chr_map
(
	input  mmc1_pkg::ppu_bus_t   ppu,
	input  mmc1_pkg::sys_cfg_t   cfg,
	input  mmc1_pkg::mmc1_regs_t regs,
	output logic [4:0]           chr_bank,
	output mmc1_pkg::chr_addr_t  chr_addr,
	output logic                 chr_oe,
	output logic                 chr_ce,
	output logic                 chr_we,
	output logic                 ciram_a10,
	output logic                 ciram_ce
);

	logic a12;

	assign a12 = ppu.addr[12];

	always_comb
	begin
		if (!regs.r0[4])
			chr_bank = {regs.r1[4:1], a12}; // 8K mode.
		else if (!a12)
			chr_bank = regs.r1;
		else
			chr_bank = regs.r2;
	end

	// CHR RAM is only 8 KiB, keep the low bank bit.
	assign chr_addr = {cfg.chr_ram ? {4'b0000, chr_bank[0]} : chr_bank, ppu.addr[11:0]};

	// One-screen A/B, then vertical and horizontal.
	always_comb
	begin
		case (regs.r0[1:0])
			2'd0: ciram_a10 = 1'b0;
			2'd1: ciram_a10 = 1'b1;
			2'd2: ciram_a10 = ppu.addr[10];
			default: ciram_a10 = ppu.addr[11];
		endcase
	end

	assign ciram_ce = !ppu.addr[13];
	assign chr_ce   = ciram_ce;
	assign chr_oe   = !ppu.oe;
	assign chr_we   = cfg.chr_ram && !ppu.we && ciram_ce; // ROM boards never write.

endmodule

/* verilog/mmc1_prg_map.sv */
`timescale 1ns/1ps

module mmc1_prg_map
(
	input  mmc1_pkg::cpu_bus_t   cpu,
	input  mmc1_pkg::sys_cfg_t   cfg,
	input  mmc1_pkg::mmc1_regs_t regs,
	input  logic [4:0]           chr_bank,
	output mmc1_pkg::prg_addr_t  prg_addr,
	output logic                 prg_oe,
	output logic                 rom_ce,
	output logic                 ram_ce,
	output logic                 ram_we,
	output mmc1_pkg::srm_addr_t  srm_addr
);

	logic [3:0] prg_bank;
	logic [1:0] srm_bank;
	logic       a14;

	assign a14 = cpu.addr[14];

	always_comb
	begin
		if (!regs.r0[3])
			prg_bank = {regs.r3[3:1], a14}; // 32K mode.
		else if (regs.r0[2] != a14)
			prg_bank = regs.r3[3:0]; // Switchable half.
		else if (!a14)
			prg_bank = 4'h0;
		else
			prg_bank = 4'hf;
	end

	// Submapper 5 has no PRG banking at bit 14.
	assign prg_addr = {chr_bank[4], prg_bank[3:1],
		(cfg.map_sub == 4'd5) ? a14 : prg_bank[0], cpu.addr[13:0]};

	assign prg_oe = cpu.rw;
	assign rom_ce = cpu.addr[15];
	assign ram_ce = (cpu.addr[15:13] == 3'b011); // 6000 to 7FFF.
	assign ram_we = ram_ce && !cpu.rw;

	// CHR RAM boards reuse CHR bank bits as the save RAM bank.
	assign srm_bank = cfg.chr_ram ? chr_bank[3:2] : 2'b00;
	assign srm_addr = {srm_bank, cpu.addr[12:0]};

endmodule

/* verilog/mmc1_serial_ctrl.sv */
`timescale 1ns/1ps
`include "mmc1_defines.svh"

module mmc1_serial_ctrl
(
	input  logic                 m2,
	input  logic                 map_rst,
	input  mmc1_pkg::cpu_bus_t   cpu,
	input  mmc1_pkg::ss_ctrl_t   ss,
	output mmc1_pkg::mmc1_regs_t regs,
	output mmc1_pkg::cpu_data_t  ss_rdat
);

	// Only bit 4 set, five bits still to come.
	localparam mmc1_pkg::mmc_reg_t BUFF_EMPTY = 5'b10000;

	mmc1_pkg::wr_state_t  wr_st;
	mmc1_pkg::mmc1_regs_t regs_q;
	mmc1_pkg::mmc_reg_t   shift_val;
	mmc1_pkg::mmc_reg_t   ss_reg;
	logic                 reg_acc;
	logic                 reg_we;
	logic                 reg_rst;
	logic                 ss_wr;

	// Second write of a back-to-back pair is dropped.
	assign reg_acc   = cpu.addr[15] && !cpu.rw && (wr_st == mmc1_pkg::WR_IDLE);
	assign reg_we    = reg_acc && !ss.act; // Save-state access owns the registers.
	assign reg_rst   = reg_we && cpu.dat[7];
	assign ss_wr     = ss.act && ss.we;
	assign shift_val = {cpu.dat[0], regs_q.buff[4:1]}; // LSB first.

	always_ff @(posedge m2)
	begin
		if (map_rst)
			wr_st <= mmc1_pkg::WR_IDLE;
		else if (reg_acc)
			wr_st <= mmc1_pkg::WR_HELD;
		else
			wr_st <= mmc1_pkg::WR_IDLE;
	end

	always_ff @(posedge m2)
	begin
		if (ss_wr)
		begin
			if (ss.addr[7:2] == 6'd0)
			begin
				case (ss.addr[1:0])
					2'd0: regs_q.r0 <= cpu.dat[4:0];
					2'd1: regs_q.r1 <= cpu.dat[4:0];
					2'd2: regs_q.r2 <= cpu.dat[4:0];
					default: regs_q.r3 <= cpu.dat[4:0];
				endcase
			end
			if (ss.addr == `MMC1_SS_BUFF_ADDR)
				regs_q.buff <= cpu.dat[4:0];
		end
		else if (map_rst)
		begin
			regs_q.r0   <= `MMC1_R0_RST;
			regs_q.r1   <= '0;
			regs_q.r2   <= '0;
			regs_q.r3   <= '0;
			regs_q.buff <= BUFF_EMPTY;
		end
		else if (reg_rst)
		begin
			regs_q.buff     <= BUFF_EMPTY;
			regs_q.r0[3:2]  <= 2'b11; // Back to 16K mode, last bank fixed.
		end
		else if (reg_we)
		begin
			if (!regs_q.buff[0])
				regs_q.buff <= shift_val;
			else
			begin
				// Marker reached bit 0, this is the fifth bit.
				regs_q.buff <= BUFF_EMPTY;
				case (cpu.addr[14:13])
					2'd0: regs_q.r0 <= shift_val;
					2'd1: regs_q.r1 <= shift_val;
					2'd2: regs_q.r2 <= shift_val;
					default: regs_q.r3 <= shift_val;
				endcase
			end
		end
	end

	assign regs = regs_q;

	always_comb
	begin
		case (ss.addr[1:0])
			2'd0: ss_reg = regs_q.r0;
			2'd1: ss_reg = regs_q.r1;
			2'd2: ss_reg = regs_q.r2;
			default: ss_reg = regs_q.r3;
		endcase
		if (ss.addr[7:2] == 6'd0)
			ss_rdat = {3'b000, ss_reg};
		else if (ss.addr == `MMC1_SS_BUFF_ADDR)
			ss_rdat = {3'b000, regs_q.buff};
		else if (ss.addr == `MMC1_SS_ID_ADDR)
			ss_rdat = `MMC1_MAP_NUM;
		else
			ss_rdat = 8'hff;
	end

	// Shifting never loses the marker once it is present.
	a_buff_marker: assert property (@(posedge m2) disable iff (map_rst)
		($past(regs_q.buff) != '0) && !$past(ss_wr) |-> (regs_q.buff != '0));

	// A save-state read leaves every register untouched.
	a_ss_read_stable: assert property (@(posedge m2)
		ss.act && !ss.we && !map_rst |=> $stable(regs_q));

endmodule

/* verilog/mmc1_pkg.sv */
package mmc1_pkg;

	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  cpu_data_t;
	typedef logic [13:0] ppu_addr_t;
	typedef logic [18:0] prg_addr_t; // 512 KiB PRG ROM.
	typedef logic [16:0] chr_addr_t;
	typedef logic [14:0] srm_addr_t; // 4 banks of 8 KiB.
	typedef logic [4:0]  mmc_reg_t;
	typedef logic [7:0]  ss_addr_t;

	// CPU side, rw high means read.
	typedef struct packed {
		cpu_addr_t addr;
		cpu_data_t dat;
		logic      rw;
	} cpu_bus_t;

	// PPU side, strobes active low.
	typedef struct packed {
		ppu_addr_t addr;
		logic      oe;
		logic      we;
	} ppu_bus_t;

	typedef struct packed {
		logic       chr_ram; // Board has CHR RAM instead of ROM.
		logic [3:0] map_sub;
	} sys_cfg_t;

	typedef struct packed {
		logic     act;
		logic     we;
		ss_addr_t addr;
	} ss_ctrl_t;

	typedef struct packed {
		mmc_reg_t r0;
		mmc_reg_t r1;
		mmc_reg_t r2;
		mmc_reg_t r3;
		mmc_reg_t buff; // Serial shift register with marker bit.
	} mmc1_regs_t;

	typedef struct packed {
		prg_addr_t prg_addr;
		logic      prg_oe;
		logic      rom_ce;
		logic      ram_ce;
		logic      ram_we;
		srm_addr_t srm_addr;
		chr_addr_t chr_addr;
		logic      chr_oe;
		logic      chr_ce;
		logic      chr_we;
		logic      ciram_a10;
		logic      ciram_ce;
	} map_out_t;

	// Previous cycle held an accepted register write.
	typedef enum logic {
		WR_IDLE,
		WR_HELD
	} wr_state_t;

endpackage

/* verilog/mmc1_defines.svh */
`ifndef MMC1_DEFINES_SVH
`define MMC1_DEFINES_SVH

// Mapper number reported on the save-state port.
`define MMC1_MAP_NUM 8'd1

// Power-up value of r0. 16K PRG with last bank fixed, 4K CHR.
`define MMC1_R0_RST 5'b11111

// Save-state address of the shift register.
`define MMC1_SS_BUFF_ADDR 8'd4

// Save-state address returning the mapper number.
`define MMC1_SS_ID_ADDR 8'd127

`endif
